/* hw/ex_pkg.sv */
package ex_pkg;

  // Datapath widths
  localparam int unsigned data_width    = 32;
  localparam int unsigned id_width      = 8;
  localparam int unsigned alu_opt_width = 11;
  // Shift amount is the low bits of operand b
  localparam int unsigned shamt_width   = 5;

  // Bit positions in the one-hot ALU select bus
  localparam int unsigned alu_add  = 0;
  localparam int unsigned alu_sub  = 1;
  localparam int unsigned alu_sll  = 2;
  localparam int unsigned alu_slt  = 3;
  localparam int unsigned alu_sltu = 4;
  localparam int unsigned alu_xor  = 5;
  localparam int unsigned alu_srl  = 6;
  localparam int unsigned alu_sra  = 7;
  localparam int unsigned alu_or   = 8;
  localparam int unsigned alu_and  = 9;
  localparam int unsigned alu_pc   = 10;

  // Operation class from the front end
  typedef enum logic [2:0] {
    op_reg   = 3'd0,
    op_imm   = 3'd1,
    op_lui   = 3'd2,
    op_auipc = 3'd3,
    op_link  = 3'd4
  } op_class_e;

  // Request as presented to the stage
  typedef struct packed {
    logic [id_width-1:0]   id;
    op_class_e             op_class;
    logic [2:0]            funct3;
    logic                  funct7_5;
    logic [data_width-1:0] rs1_data;
    logic [data_width-1:0] rs2_data;
    logic [data_width-1:0] imm;
    logic [data_width-1:0] pc;
  } ex_req_t;

  // Decoded item held in the first slot
  typedef struct packed {
    logic [id_width-1:0]      id;
    logic [alu_opt_width-1:0] alu_opt_bus;
    logic [data_width-1:0]    alu_a_data;
    logic [data_width-1:0]    alu_b_data;
    logic [data_width-1:0]    pc;
  } ex_dec_t;

  // Tagged result
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] result;
  } ex_rsp_t;

endpackage

/* hw/ex_pipe_reg.sv */
`timescale 1ns/1ns

module ex_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     valid_q;
  payload_t data_q;

  // Accept when empty or when the held item leaves this cycle
  assign in_ready  = ~valid_q | out_ready;
  assign out_valid = valid_q;
  assign out_data  = data_q;

  // Occupancy flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      // New item replaces the leaving one, or slot drains
      valid_q <= in_valid;
    end
  end

  // Payload storage, loaded only on a transfer in
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  // A stalled item stays offered and unchanged
  a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

/* hw/ex_op_decode.sv */
`timescale 1ns/1ns

module ex_op_decode (
  input  logic                             clk,
  input  logic                             rst_n,
  // Sampling enable for the one-hot check
  input  logic                             in_valid,
  input  ex_pkg::ex_req_t                  req,
  output logic [ex_pkg::alu_opt_width-1:0] alu_opt_bus,
  output logic [ex_pkg::data_width-1:0]    alu_a_data,
  output logic [ex_pkg::data_width-1:0]    alu_b_data
);

  // funct3 to select bit position
  // alt marks funct7_5 as meaningful for this class
  function automatic int unsigned funct_sel(input logic [2:0] funct3,
                                            input logic       funct7_5,
                                            input logic       alt_add);
    int unsigned sel;
    case (funct3)
      3'b000:  sel = (alt_add && funct7_5) ? ex_pkg::alu_sub : ex_pkg::alu_add;
      3'b001:  sel = ex_pkg::alu_sll;
      3'b010:  sel = ex_pkg::alu_slt;
      3'b011:  sel = ex_pkg::alu_sltu;
      3'b100:  sel = ex_pkg::alu_xor;
      // SRA and SRAI both take funct7_5
      3'b101:  sel = funct7_5 ? ex_pkg::alu_sra : ex_pkg::alu_srl;
      3'b110:  sel = ex_pkg::alu_or;
      default: sel = ex_pkg::alu_and;
    endcase
    return sel;
  endfunction

  always_comb begin
    alu_opt_bus = '0;
    alu_a_data  = '0;
    alu_b_data  = '0;
    case (req.op_class)
      ex_pkg::op_reg: begin
        // SUB only exists for register-register
        alu_opt_bus[funct_sel(req.funct3, req.funct7_5, 1'b1)] = 1'b1;
        alu_a_data = req.rs1_data;
        alu_b_data = req.rs2_data;
      end
      ex_pkg::op_imm: begin
        // ADDI ignores funct7_5
        alu_opt_bus[funct_sel(req.funct3, req.funct7_5, 1'b0)] = 1'b1;
        alu_a_data = req.rs1_data;
        alu_b_data = req.imm;
      end
      ex_pkg::op_lui: begin
        // Zero plus immediate
        alu_opt_bus[ex_pkg::alu_add] = 1'b1;
        alu_b_data = req.imm;
      end
      ex_pkg::op_auipc: begin
        alu_opt_bus[ex_pkg::alu_add] = 1'b1;
        alu_a_data = req.pc;
        alu_b_data = req.imm;
      end
      ex_pkg::op_link: begin
        // Link address comes from the adder's pc path
        alu_opt_bus[ex_pkg::alu_pc] = 1'b1;
      end
      default: begin
        alu_opt_bus[ex_pkg::alu_add] = 1'b1;
      end
    endcase
  end

  // Exactly one operation per offered request
  a_sel_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> $onehot(alu_opt_bus));

endmodule

/* hw/ex_adder.sv */
`timescale 1ns/1ns

module ex_adder (
  input  logic [ex_pkg::alu_opt_width-1:0] alu_opt_bus,
  input  logic [ex_pkg::data_width-1:0]    alu_a_data,
  input  logic [ex_pkg::data_width-1:0]    alu_b_data,
  input  logic [ex_pkg::data_width-1:0]    pc,
  output logic [ex_pkg::data_width-1:0]    adder_sum,
  output logic [ex_pkg::data_width-1:0]    adder_pc,
  output logic                             signed_flag,
  output logic                             unsigned_flag
);

  localparam int unsigned msb = ex_pkg::data_width - 1;

  logic                         do_sub;
  logic [ex_pkg::data_width-1:0] b_in;
  logic                         carry_out;

  // Compares reuse the subtract path
  assign do_sub = alu_opt_bus[ex_pkg::alu_sub]
                | alu_opt_bus[ex_pkg::alu_slt]
                | alu_opt_bus[ex_pkg::alu_sltu];

  // Two's complement through inverted b and carry in
  assign b_in = do_sub ? ~alu_b_data : alu_b_data;

  // One wide adder, carry out kept for the unsigned compare
  assign {carry_out, adder_sum} = {1'b0, alu_a_data} + {1'b0, b_in}
                                + {{ex_pkg::data_width{1'b0}}, do_sub};

  // Signs differ, a is negative means a < b
  // Signs equal, the difference sign decides
  assign signed_flag = (alu_a_data[msb] != alu_b_data[msb]) ? alu_a_data[msb]
                                                            : adder_sum[msb];

  // No carry out of a - b means a borrowed, so a < b
  assign unsigned_flag = ~carry_out;

  // Return address for jal/jalr
  assign adder_pc = pc + ex_pkg::data_width'(4);

endmodule

/* hw/ex_alu.sv */
`timescale 1ns/1ns

module ex_alu (
  input  logic [ex_pkg::alu_opt_width-1:0] alu_opt_bus,
  input  logic [ex_pkg::data_width-1:0]    alu_a_data,
  input  logic [ex_pkg::data_width-1:0]    alu_b_data,
  input  logic [ex_pkg::data_width-1:0]    adder_sum,
  input  logic [ex_pkg::data_width-1:0]    adder_pc,
  input  logic                             signed_flag,
  input  logic                             unsigned_flag,
  output logic [ex_pkg::data_width-1:0]    alu_out_data
);

  localparam int unsigned w = ex_pkg::data_width;

  logic [w-1:0]                    and_res;
  logic [w-1:0]                    or_res;
  logic [w-1:0]                    xor_res;
  logic [w-1:0]                    slt_res;
  logic [w-1:0]                    sltu_res;
  logic [ex_pkg::shamt_width-1:0]  shamt;
  logic [w-1:0]                    shift_in;
  logic [w-1:0]                    shift_out;
  logic [w-1:0]                    sra_mask;
  logic [w-1:0]                    sll_res;
  logic [w-1:0]                    srl_res;
  logic [w-1:0]                    sra_res;

  // Mirror a word end to end
  function automatic logic [w-1:0] bit_reverse(input logic [w-1:0] v);
    logic [w-1:0] r;
    for (int i = 0; i < w; i++) begin
      r[w-1-i] = v[i];
    end
    return r;
  endfunction

  // Bitwise logic
  assign and_res = alu_a_data & alu_b_data;
  assign or_res  = alu_a_data | alu_b_data;
  assign xor_res = alu_a_data ^ alu_b_data;

  // Compare flags widened with zeros
  assign slt_res  = {{(w-1){1'b0}}, signed_flag};
  assign sltu_res = {{(w-1){1'b0}}, unsigned_flag};

  assign shamt = alu_b_data[ex_pkg::shamt_width-1:0];

  // Single right shifter, left shift works on the mirrored word
  assign shift_in  = alu_opt_bus[ex_pkg::alu_sll] ? bit_reverse(alu_a_data) : alu_a_data;
  assign shift_out = shift_in >> shamt;

  assign srl_res = shift_out;
  assign sll_res = bit_reverse(shift_out);

  // Mask has ones where shifted data landed, zeros get the sign
  assign sra_mask = {w{1'b1}} >> shamt;
  assign sra_res  = shift_out | ({w{alu_a_data[w-1]}} & ~sra_mask);

  // AND-OR merge, select bus is one-hot
  assign alu_out_data =
      ({w{alu_opt_bus[ex_pkg::alu_add]}}  & adder_sum) |
      ({w{alu_opt_bus[ex_pkg::alu_sub]}}  & adder_sum) |
      ({w{alu_opt_bus[ex_pkg::alu_sll]}}  & sll_res)   |
      ({w{alu_opt_bus[ex_pkg::alu_slt]}}  & slt_res)   |
      ({w{alu_opt_bus[ex_pkg::alu_sltu]}} & sltu_res)  |
      ({w{alu_opt_bus[ex_pkg::alu_xor]}}  & xor_res)   |
      ({w{alu_opt_bus[ex_pkg::alu_srl]}}  & srl_res)   |
      ({w{alu_opt_bus[ex_pkg::alu_sra]}}  & sra_res)   |
      ({w{alu_opt_bus[ex_pkg::alu_or]}}   & or_res)    |
      ({w{alu_opt_bus[ex_pkg::alu_and]}}  & and_res)   |
      ({w{alu_opt_bus[ex_pkg::alu_pc]}}   & adder_pc);

endmodule

/* hw/ex_stage.sv */
`timescale 1ns/1ns

module ex_stage (
  input  logic            clk,
  input  logic            rst_n,
  // Request channel
  input  logic            in_valid,
  output logic            in_ready,
  input  ex_pkg::ex_req_t in_req,
  // Response channel
  output logic            out_valid,
  input  logic            out_ready,
  output ex_pkg::ex_rsp_t out_rsp
);

  logic [ex_pkg::alu_opt_width-1:0] dec_opt_bus;
  logic [ex_pkg::data_width-1:0]    dec_a_data;
  logic [ex_pkg::data_width-1:0]    dec_b_data;
  ex_pkg::ex_dec_t                  dec_item;
  ex_pkg::ex_dec_t                  s1_item;
  logic                             s1_valid;
  logic                             s2_ready;
  logic [ex_pkg::data_width-1:0]    adder_sum;
  logic [ex_pkg::data_width-1:0]    adder_pc;
  logic                             signed_flag;
  logic                             unsigned_flag;
  logic [ex_pkg::data_width-1:0]    alu_result;
  ex_pkg::ex_rsp_t                  rsp_item;

  // Decode ahead of the first slot
  ex_op_decode i_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .req         (in_req),
    .alu_opt_bus (dec_opt_bus),
    .alu_a_data  (dec_a_data),
    .alu_b_data  (dec_b_data)
  );

  assign dec_item.id          = in_req.id;
  assign dec_item.alu_opt_bus = dec_opt_bus;
  assign dec_item.alu_a_data  = dec_a_data;
  assign dec_item.alu_b_data  = dec_b_data;
  assign dec_item.pc          = in_req.pc;

  // Slot 1 holds the decoded item
  ex_pipe_reg #(.payload_t(ex_pkg::ex_dec_t)) i_slot_dec (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (dec_item),
    .out_valid (s1_valid),
    .out_ready (s2_ready),
    .out_data  (s1_item)
  );

  // Execute between the slots
  ex_adder i_adder (
    .alu_opt_bus   (s1_item.alu_opt_bus),
    .alu_a_data    (s1_item.alu_a_data),
    .alu_b_data    (s1_item.alu_b_data),
    .pc            (s1_item.pc),
    .adder_sum     (adder_sum),
    .adder_pc      (adder_pc),
    .signed_flag   (signed_flag),
    .unsigned_flag (unsigned_flag)
  );

  ex_alu i_alu (
    .alu_opt_bus   (s1_item.alu_opt_bus),
    .alu_a_data    (s1_item.alu_a_data),
    .alu_b_data    (s1_item.alu_b_data),
    .adder_sum     (adder_sum),
    .adder_pc      (adder_pc),
    .signed_flag   (signed_flag),
    .unsigned_flag (unsigned_flag),
    .alu_out_data  (alu_result)
  );

  assign rsp_item.id     = s1_item.id;
  assign rsp_item.result = alu_result;

  // Slot 2 drives the response channel
  ex_pipe_reg #(.payload_t(ex_pkg::ex_rsp_t)) i_slot_rsp (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (s1_valid),
    .in_ready  (s2_ready),
    .in_data   (rsp_item),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_rsp)
  );

endmodule

/* tb/ex_checker.sv */
`timescale 1ns/1ns

module ex_checker (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  input  logic            in_ready,
  input  ex_pkg::ex_req_t in_req,
  input  logic            out_valid,
  input  logic            out_ready,
  input  ex_pkg::ex_rsp_t out_rsp,
  // Demands the fixed two-edge latency and an accept every cycle
  input  logic            lat_check,
  output int              errors,
  output int              checked,
  output int              pending
);

  ex_pkg::ex_rsp_t exp_q[$];
  int              acc_q[$];
  int              cycle;
  logic            stalled;
  ex_pkg::ex_rsp_t held;

  // Expected response straight from the RV32I rules
  function automatic ex_pkg::ex_rsp_t ref_rsp(input ex_pkg::ex_req_t r);
    ex_pkg::ex_rsp_t rsp;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     res;
    logic [4:0]      sh;
    a   = r.rs1_data;
    b   = (r.op_class == ex_pkg::op_reg) ? r.rs2_data : r.imm;
    sh  = b[4:0];
    res = '0;
    case (r.op_class)
      ex_pkg::op_reg, ex_pkg::op_imm: begin
        case (r.funct3)
          // Only register form has SUB
          3'b000: res = (r.op_class == ex_pkg::op_reg && r.funct7_5) ? a - b : a + b;
          3'b001: res = a << sh;
          3'b010: res = {31'd0, $signed(a) < $signed(b)};
          3'b011: res = {31'd0, a < b};
          3'b100: res = a ^ b;
          3'b101: res = r.funct7_5 ? 32'($signed(a) >>> sh) : a >> sh;
          3'b110: res = a | b;
          default: res = a & b;
        endcase
      end
      ex_pkg::op_lui:   res = r.imm;
      ex_pkg::op_auipc: res = r.pc + r.imm;
      ex_pkg::op_link:  res = r.pc + 32'd4;
      default:          res = '0;
    endcase
    rsp.id     = r.id;
    rsp.result = res;
    return rsp;
  endfunction

  initial begin
    errors  = 0;
    checked = 0;
    pending = 0;
  end

  // Sampled at the edge, before the DUT registers move
  always @(posedge clk) begin
    ex_pkg::ex_rsp_t e;
    int              acc;
    if (!rst_n) begin
      cycle   = 0;
      stalled = 1'b0;
    end else begin
      cycle++;
      // A stalled response must stay offered and unchanged
      if (stalled && (!out_valid || out_rsp !== held)) begin
        $display("out_rsp changed or was withdrawn while stalled at cycle %0d", cycle);
        errors++;
      end
      // Back-to-back requests must all be taken at once
      if (lat_check && in_valid && !in_ready) begin
        $display("request id %h was refused during the burst at cycle %0d",
                 in_req.id, cycle);
        errors++;
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(ref_rsp(in_req));
        acc_q.push_back(cycle);
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("response arrived with no request outstanding at cycle %0d", cycle);
          errors++;
        end else begin
          e   = exp_q.pop_front();
          acc = acc_q.pop_front();
          checked++;
          if (out_rsp.id !== e.id) begin
            $display("[FAIL] out_rsp.id expected %h got %h", e.id, out_rsp.id);
            errors++;
          end
          if (out_rsp.result !== e.result) begin
            $display("[FAIL] out_rsp.result expected %h got %h (id %h)",
                     e.result, out_rsp.result, e.id);
            errors++;
          end
          // Accepted at edge k, taken at edge k+2
          if (lat_check && cycle - acc != 2) begin
            $display("response id %h took %0d cycles instead of 2", e.id, cycle - acc);
            errors++;
          end
        end
      end
      stalled = out_valid && !out_ready;
      held    = out_rsp;
      pending = exp_q.size();
    end
  end

endmodule

/* tb/tb_ex_stage.sv */
`timescale 1ns/1ns

module tb_ex_stage;

  // Transaction counts per test
  localparam int n_reg     = 256;
  localparam int n_imm     = 65;
  localparam int n_upper   = 24;
  localparam int n_mixed   = 200;
  localparam int n_burst   = 32;
  localparam int total_tx  = n_reg + n_imm + n_upper + n_mixed + n_burst;
  localparam int timeout_ns = total_tx * 10 * 4 + 1000;

  logic            clk;
  logic            rst_n;
  logic            in_valid;
  logic            in_ready;
  ex_pkg::ex_req_t in_req;
  logic            out_valid;
  logic            out_ready;
  ex_pkg::ex_rsp_t out_rsp;
  logic            rand_ready;
  logic            lat_check;
  logic [31:0]     lfsr_state;
  logic [7:0]      next_id;
  int              tb_errors;
  int              chk_errors;
  int              chk_count;
  int              chk_pending;

  ex_stage i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp)
  );

  ex_checker i_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp),
    .lat_check (lat_check),
    .errors    (chk_errors),
    .checked   (chk_count),
    .pending   (chk_pending)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Zero, all ones, sign bit alone, or random
  function automatic logic [31:0] edge_val(input int k);
    case (k)
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h8000_0000;
      default: return rand_bits(32);
    endcase
  endfunction

  task automatic drive_ready();
    out_ready = rand_ready ? (rand_bits(1) != 0) : 1'b1;
  endtask

  // Hold the request until the edge that takes it
  task automatic send(input ex_pkg::ex_req_t r);
    logic taken;
    in_req   = r;
    in_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = in_ready;
      #1;
      drive_ready();
    end
    in_valid = 1'b0;
  endtask

  task automatic send_op(input ex_pkg::op_class_e cls, input logic [2:0] f3,
                         input logic f7, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] imm, input logic [31:0] pc);
    ex_pkg::ex_req_t r;
    r.id       = next_id;
    r.op_class = cls;
    r.funct3   = f3;
    r.funct7_5 = f7;
    r.rs1_data = a;
    r.rs2_data = b;
    r.imm      = imm;
    r.pc       = pc;
    next_id++;
    send(r);
  endtask

  // Empty the pipeline with the sink always ready
  task automatic drain();
    rand_ready = 1'b0;
    out_ready  = 1'b1;
    while (chk_pending != 0 || out_valid) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report(input int num, input string name);
    $display("test %0d %s: done, %0d errors so far", num, name, tb_errors + chk_errors);
  endtask

  // Bound on the whole run
  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns before the tests completed", timeout_ns);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    logic [31:0]        r;
    ex_pkg::op_class_e  cls;
    in_valid   = 1'b0;
    in_req     = '0;
    out_ready  = 1'b1;
    rst_n      = 1'b0;
    rand_ready = 1'b0;
    lat_check  = 1'b0;
    lfsr_state = 32'h0c2a5079;
    next_id    = '0;
    tb_errors  = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle state right after reset
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
      $display("after reset out_valid was not low or in_ready was not high");
      tb_errors++;
    end
    report(1, "reset state");

    for (int f3 = 0; f3 < 8; f3++) begin
      for (int f7 = 0; f7 < 2; f7++) begin
        for (int i = 0; i < 4; i++) begin
          for (int j = 0; j < 4; j++) begin
            send_op(ex_pkg::op_reg, f3[2:0], f7[0], edge_val(i), edge_val(j),
                    rand_bits(32), rand_bits(32));
          end
        end
      end
    end
    drain();
    report(2, "register-register");

    // ADDI with funct7_5 set is still an add
    send_op(ex_pkg::op_imm, 3'b000, 1'b1, rand_bits(32), rand_bits(32),
            32'h0000_0123, 32'h0);
    for (int i = 0; i < n_imm - 1; i++) begin
      r = rand_bits(12);
      send_op(ex_pkg::op_imm, 3'(rand_bits(3)), rand_bits(1) != 0, rand_bits(32),
              rand_bits(32), {{20{r[11]}}, r[11:0]}, rand_bits(32));
    end
    drain();
    report(3, "register-immediate");

    for (int i = 0; i < n_upper; i++) begin
      cls = (i % 3 == 0) ? ex_pkg::op_lui : (i % 3 == 1) ? ex_pkg::op_auipc : ex_pkg::op_link;
      send_op(cls, 3'(rand_bits(3)), rand_bits(1) != 0, rand_bits(32), rand_bits(32),
              rand_bits(20) << 12, rand_bits(30) << 2);
    end
    drain();
    report(4, "lui auipc link");

    // Random classes against a random sink
    rand_ready = 1'b1;
    for (int i = 0; i < n_mixed; i++) begin
      cls = ex_pkg::op_class_e'(3'(rand_bits(3) % 5));
      send_op(cls, 3'(rand_bits(3)), rand_bits(1) != 0, rand_bits(32), rand_bits(32),
              rand_bits(32), rand_bits(30) << 2);
    end
    drain();
    report(5, "random back-pressure");

    // Back-to-back burst, one response per cycle
    lat_check = 1'b1;
    for (int i = 0; i < n_burst; i++) begin
      send_op(ex_pkg::op_reg, 3'(rand_bits(3)), rand_bits(1) != 0, rand_bits(32),
              rand_bits(32), rand_bits(32), rand_bits(32));
    end
    drain();
    lat_check = 1'b0;
    report(6, "burst latency");

    if (chk_count != total_tx) begin
      $display("expected %0d responses but only %0d were checked", total_tx, chk_count);
      tb_errors++;
    end
    $display("checked %0d responses, %0d errors", chk_count, tb_errors + chk_errors);
    if (tb_errors + chk_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
hw/ex_pkg.sv
hw/ex_pipe_reg.sv
hw/ex_op_decode.sv
hw/ex_adder.sv
hw/ex_alu.sv
hw/ex_stage.sv
tb/ex_checker.sv
tb/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - hw/ex_pkg.sv
  - hw/ex_pipe_reg.sv
  - hw/ex_op_decode.sv
  - hw/ex_adder.sv
  - hw/ex_alu.sv
  - hw/ex_stage.sv
  - target: simulation
    files:
      - tb/ex_checker.sv
      - tb/tb_ex_stage.sv
